// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT      ?= --lint-only -Wall --timing
TOP       ?= icache_tb
FILELIST  ?= icache.f
RUNARGS   ?= +verilator+error+limit+1000
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	// fetch request
	input  logic                      req_valid,
	input  logic [`ICACHE_ADDR_W-1:0] req_addr,
	output logic                      req_ready,
	// response to IF/ID
	output logic                      resp_valid,
	output inst_t                     resp_inst,
	input  logic                      resp_ready,
	// tag array
	input  way_mask_t                 hit,
	output logic                      fill,
	output way_mask_t                 fill_way,
	output set_idx_t                  fill_idx,
	output tag_t                      fill_tag,
	// data srams, shared address and data, one enable per way
	output way_mask_t                 sram_cen,
	output logic                      sram_wen,
	output set_idx_t                  sram_addr,
	output icache_line_u              sram_din,
	input  icache_line_u              dout0,
	input  icache_line_u              dout1,
	input  icache_line_u              dout2,
	input  icache_line_u              dout3,
	// refill master
	output logic                      refill_start,
	output logic [`ICACHE_ADDR_W-1:0] refill_addr,
	input  icache_line_u              refill_line,
	input  logic                      refill_done
);

	logic              accept;
	logic              req_hit;
	logic              busy;
	// refill outstanding for the accepted miss
	logic              miss_wait;
	// outstanding refill was flushed, install only
	logic              drop_q;
	// current response comes from the captured line
	logic              from_line_q;
	way_mask_t         victim;
	// accepted request, like addr_prev and way_hit_prev
	way_mask_t         hit_q;
	set_idx_t          idx_q;
	tag_t              tag_q;
	logic [BEAT_W-1:0] wsel_q;
	icache_line_u      fill_line_q;
	icache_line_u      way_line;
	icache_line_u      resp_line;

	assign req_hit = |hit;
	assign accept  = req_valid && req_ready;

	// a miss holds the port until its response is consumed
	assign busy = miss_wait || (resp_valid && from_line_q);
	assign req_ready = !busy && (!resp_valid || resp_ready) && !flush;

	// refill starts right at acceptance
	assign refill_start = accept && !req_hit;
	assign refill_addr  = {req_addr[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// install into the victim way when the last beat lands
	assign fill     = miss_wait && refill_done;
	assign fill_way = victim;
	assign fill_idx = idx_q;
	assign fill_tag = tag_q;

	// only the hit way reads, only the victim way writes
	assign sram_cen  = ~(({`ICACHE_WAYS{accept}} & hit) | ({`ICACHE_WAYS{fill}} & victim));
	assign sram_wen  = ~fill;
	assign sram_addr = fill ? idx_q : req_addr[OFFSET_W +: IDX_W];
	assign sram_din  = refill_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid  <= 1'b0;
			miss_wait   <= 1'b0;
			drop_q      <= 1'b0;
			from_line_q <= 1'b0;
			victim      <= way_mask_t'(1);
		end else begin
			if (fill) begin
				miss_wait <= 1'b0;
				drop_q    <= 1'b0;
				// rotate one-hot, once per fill
				victim    <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
			end
			if (flush) begin
				// kill the waiting answer, a running refill still installs
				resp_valid <= 1'b0;
				if (miss_wait && !fill) begin
					drop_q <= 1'b1;
				end
			end else if (fill) begin
				resp_valid  <= !drop_q;
				from_line_q <= 1'b1;
			end else if (accept) begin
				resp_valid  <= req_hit;
				miss_wait   <= !req_hit;
				from_line_q <= 1'b0;
			end else if (resp_valid && resp_ready) begin
				resp_valid <= 1'b0;
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (accept) begin
			hit_q  <= hit;
			idx_q  <= req_addr[OFFSET_W +: IDX_W];
			tag_q  <= req_addr[`ICACHE_ADDR_W-1 -: TAG_W];
			wsel_q <= req_addr[OFFSET_W-1 -: BEAT_W];
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			fill_line_q <= refill_line;
		end
	end

	// sram output of the way that hit
	always_comb begin
		case (hit_q)
			4'b0010: way_line = dout1;
			4'b0100: way_line = dout2;
			4'b1000: way_line = dout3;
			default: way_line = dout0;
		endcase
	end

	assign resp_line = from_line_q ? fill_line_q : way_line;
	assign resp_inst = resp_line.word[wsel_q];

endmodule

// ==== hw/icache_data_sram.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data_sram import icache_pkg::*; (
	input  logic         clk,
	input  logic         cen,
	input  logic         wen,
	input  set_idx_t     addr,
	input  icache_line_u din,
	output icache_line_u dout
);

	// one line per set
	logic [LINE_W-1:0] mem [`ICACHE_SETS];

	// single port, registered read
	// with cen high nothing changes, so dout keeps the last read
	always_ff @(posedge clk) begin
		if (!cen) begin
			if (!wen) begin
				mem[addr] <= din.flat;
			end else begin
				dout.flat <= mem[addr];
			end
		end
	end

endmodule

// ==== hw/icache_pkg.sv ====
`include "icache_settings.svh"

package icache_pkg;

	// geometry derived from the settings header
	localparam int LINE_W   = `ICACHE_LINE_BYTES * 8;
	localparam int WORD_CNT = LINE_W / `ICACHE_BUS_W;
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
	localparam int IDX_W    = $clog2(`ICACHE_SETS);
	localparam int TAG_W    = `ICACHE_ADDR_W - IDX_W - OFFSET_W;
	// word select inside a line, also the refill beat counter
	localparam int BEAT_W   = $clog2(WORD_CNT);

	typedef logic [IDX_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] tag_t;
	// one bit per way, one-hot for hits and for the victim
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;
	typedef logic [31:0] inst_t;

	// one line: flat for the sram, word-wise for fill and select
	typedef union packed {
		logic [LINE_W-1:0]                         flat;
		logic [WORD_CNT-1:0][`ICACHE_BUS_W-1:0]    word;
	} icache_line_u;

endpackage

// ==== hw/icache_refill_wb.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_refill_wb import icache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	// request from the cache control
	input  logic                      start,
	input  logic [`ICACHE_ADDR_W-1:0] line_addr,
	output icache_line_u              line,
	output logic                      line_done,
	// wishbone classic master
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic [`ICACHE_ADDR_W-1:0] wb_adr,
	output logic                      wb_we,
	input  logic [`ICACHE_BUS_W-1:0]  wb_dat_i,
	input  logic                      wb_ack
);

	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(WORD_CNT - 1);

	logic [BEAT_W-1:0] beat;
	// words gathered so far
	icache_line_u      line_buf;
	logic              beat_ack;

	// read only master
	assign wb_we = 1'b0;

	assign beat_ack = wb_cyc && wb_ack;

	// bus cycle control, cyc and stb stay up across all beats
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			beat   <= '0;
		end else if (!wb_cyc) begin
			if (start) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				beat   <= '0;
			end
		end else if (wb_ack) begin
			beat <= beat + 1'b1;
			// last word in, release the bus
			if (beat == LAST_BEAT) begin
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
			end
		end
	end

	// beat address, line base then one bus word further per ack
	always_ff @(posedge clk) begin
		if (!wb_cyc && start) begin
			wb_adr <= line_addr;
		end else if (beat_ack) begin
			wb_adr <= wb_adr + `ICACHE_ADDR_W'(`ICACHE_BUS_W / 8);
		end
	end

	always_ff @(posedge clk) begin
		if (beat_ack) begin
			line_buf.word[beat] <= wb_dat_i;
		end
	end

	// the acked word is forwarded directly
	// so the complete line is there while the last ack is on the bus
	always_comb begin
		line = line_buf;
		if (beat_ack) begin
			line.word[beat] = wb_dat_i;
		end
	end

	// single cycle, only with the final ack
	assign line_done = beat_ack && (beat == LAST_BEAT);

endmodule

// ==== hw/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 64

// associativity
`define ICACHE_WAYS 4

// sets per way, 64 x 16 bytes gives 1 KiB per way
`define ICACHE_SETS 64

// bytes per cache line
`define ICACHE_LINE_BYTES 16

// wishbone data width, also the instruction width
`define ICACHE_BUS_W 32

`endif

// ==== hw/icache_tag_array.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tag_array import icache_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// lookup side, driven straight from the fetch address
	input  set_idx_t  lookup_idx,
	input  tag_t      lookup_tag,
	output way_mask_t hit,
	// install side, used once per completed refill
	input  logic      fill,
	input  way_mask_t fill_way,
	input  set_idx_t  fill_idx,
	input  tag_t      fill_tag,
	input  logic      inv_all
);

	// valid bit per way and set
	logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] vld;
	// tag storage per way
	tag_t tags [`ICACHE_WAYS][`ICACHE_SETS];

	// all ways compared in parallel
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit[w] = vld[w][lookup_idx] && (tags[w][lookup_idx] == lookup_tag);
		end
	end

	// valid bits
	// invalidate first, so a fill landing in the same cycle still sticks
	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
		end else begin
			if (inv_all) begin
				vld <= '0;
			end
			if (fill) begin
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					if (fill_way[w]) begin
						vld[w][fill_idx] <= 1'b1;
					end
				end
			end
		end
	end

	// tags only matter once the valid bit is set
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][fill_idx] <= fill_tag;
				end
			end
		end
	end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  logic                      invalidate,
	// fetch side
	input  logic                      req_valid,
	input  logic [`ICACHE_ADDR_W-1:0] req_addr,
	output logic                      req_ready,
	output logic                      resp_valid,
	output inst_t                     resp_inst,
	input  logic                      resp_ready,
	// wishbone classic master
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic [`ICACHE_ADDR_W-1:0] wb_adr,
	output logic                      wb_we,
	input  logic [`ICACHE_BUS_W-1:0]  wb_dat_i,
	input  logic                      wb_ack
);

	way_mask_t                 hit;
	logic                      fill;
	way_mask_t                 fill_way;
	set_idx_t                  fill_idx;
	tag_t                      fill_tag;
	way_mask_t                 sram_cen;
	logic                      sram_wen;
	set_idx_t                  sram_addr;
	icache_line_u              sram_din;
	icache_line_u              dout0;
	icache_line_u              dout1;
	icache_line_u              dout2;
	icache_line_u              dout3;
	logic                      refill_start;
	logic [`ICACHE_ADDR_W-1:0] refill_addr;
	icache_line_u              refill_line;
	logic                      refill_done;

	// lookup uses the live fetch address
	icache_tag_array u_tags (
		.clk        (clk),
		.rst        (rst),
		.lookup_idx (req_addr[OFFSET_W +: IDX_W]),
		.lookup_tag (req_addr[`ICACHE_ADDR_W-1 -: TAG_W]),
		.hit        (hit),
		.fill       (fill),
		.fill_way   (fill_way),
		.fill_idx   (fill_idx),
		.fill_tag   (fill_tag),
		.inv_all    (invalidate)
	);

	icache_refill_wb u_refill (
		.clk       (clk),
		.rst       (rst),
		.start     (refill_start),
		.line_addr (refill_addr),
		.line      (refill_line),
		.line_done (refill_done),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_adr    (wb_adr),
		.wb_we     (wb_we),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack)
	);

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.req_valid    (req_valid),
		.req_addr     (req_addr),
		.req_ready    (req_ready),
		.resp_valid   (resp_valid),
		.resp_inst    (resp_inst),
		.resp_ready   (resp_ready),
		.hit          (hit),
		.fill         (fill),
		.fill_way     (fill_way),
		.fill_idx     (fill_idx),
		.fill_tag     (fill_tag),
		.sram_cen     (sram_cen),
		.sram_wen     (sram_wen),
		.sram_addr    (sram_addr),
		.sram_din     (sram_din),
		.dout0        (dout0),
		.dout1        (dout1),
		.dout2        (dout2),
		.dout3        (dout3),
		.refill_start (refill_start),
		.refill_addr  (refill_addr),
		.refill_line  (refill_line),
		.refill_done  (refill_done)
	);

	// data ways
	icache_data_sram u_way0 (
		.clk  (clk),
		.cen  (sram_cen[0]),
		.wen  (sram_wen),
		.addr (sram_addr),
		.din  (sram_din),
		.dout (dout0)
	);

	icache_data_sram u_way1 (
		.clk  (clk),
		.cen  (sram_cen[1]),
		.wen  (sram_wen),
		.addr (sram_addr),
		.din  (sram_din),
		.dout (dout1)
	);

	icache_data_sram u_way2 (
		.clk  (clk),
		.cen  (sram_cen[2]),
		.wen  (sram_wen),
		.addr (sram_addr),
		.din  (sram_din),
		.dout (dout2)
	);

	icache_data_sram u_way3 (
		.clk  (clk),
		.cen  (sram_cen[3]),
		.wen  (sram_wen),
		.addr (sram_addr),
		.din  (sram_din),
		.dout (dout3)
	);

endmodule

// ==== icache.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_data_sram.sv
hw/icache_tag_array.sv
hw/icache_refill_wb.sv
hw/icache_ctrl.sv
hw/icache_top.sv
testbench/icache_wb_mem.sv
testbench/icache_assert.sv
testbench/icache_tb.sv

// ==== testbench/icache_assert.sv ====
`timescale 1ns/1ns

module icache_assert import icache_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      flush,
	input logic      resp_valid,
	input inst_t     resp_inst,
	input logic      resp_ready,
	input logic      wb_stb,
	input logic      wb_we,
	input logic      wb_ack,
	input way_mask_t hit
);

	int fail_cnt = 0;

	// waiting response stays put unless flushed
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp_inst))
		else begin $error("response changed under back-pressure"); fail_cnt++; end

	// strobe held until the slave acks
	a_stb_hold: assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb)
		else begin $error("wb_stb dropped before wb_ack"); fail_cnt++; end

	a_no_write: assert property (@(posedge clk) disable iff (rst) !wb_we)
		else begin $error("wb_we high on a read-only master"); fail_cnt++; end

	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
		else begin $error("hit mask has more than one way set"); fail_cnt++; end

endmodule

bind icache_top icache_assert u_assert (
	.clk(clk), .rst(rst), .flush(flush), .resp_valid(resp_valid), .resp_inst(resp_inst),
	.resp_ready(resp_ready), .wb_stb(wb_stb), .wb_we(wb_we), .wb_ack(wb_ack), .hit(hit)
);

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tb import icache_pkg::*; ();

	localparam int NUM_REQ   = 400;
	localparam int MAX_WAIT  = 3;
	localparam int RESET_CYC = 4;
	// four beats at worst wait plus the hit and fill overhead per request
	localparam int LIMIT     = NUM_REQ * (4 * (MAX_WAIT + 1) + 4) + RESET_CYC;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic flush = 1'b0;
	logic invalidate = 1'b0;
	logic req_valid = 1'b0;
	logic [`ICACHE_ADDR_W-1:0] req_addr = '0;
	logic resp_ready = 1'b0;
	logic stall = 1'b0;
	logic req_ready;
	logic resp_valid;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	inst_t resp_inst;
	logic [`ICACHE_ADDR_W-1:0] wb_adr;
	logic [`ICACHE_BUS_W-1:0] wb_dat;

	logic [31:0] lfsr = 32'hae6f;
	int n_acc = 0;
	int mismatch_cnt = 0;
	int other_cnt = 0;
	int cycle = 0;

	// reference model
	logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] sh_vld;
	tag_t sh_tag [`ICACHE_WAYS][`ICACHE_SETS];
	way_mask_t sh_victim;
	inst_t exp_inst [$];
	way_mask_t exp_hit [$];
	set_idx_t pend_idx;
	tag_t pend_tag;
	int beat_cnt;
	// refill of an accepted miss still running
	logic miss_pend;
	logic cyc_prev;
	logic cyc_rise;
	logic hit_acc;

	always #5 clk = ~clk;

	icache_top u_dut (
		.clk(clk), .rst(rst), .flush(flush), .invalidate(invalidate),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_inst(resp_inst), .resp_ready(resp_ready),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_we(wb_we),
		.wb_dat_i(wb_dat), .wb_ack(wb_ack)
	);

	icache_wb_mem #(.MAX_WAIT(MAX_WAIT)) u_mem (
		.clk(clk), .rst(rst), .stall(stall), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_adr(wb_adr), .wb_we(wb_we), .wb_dat(wb_dat), .wb_ack(wb_ack)
	);

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic inst_t mem_word(input logic [63:0] a);
		logic [63:0] w;
		w = a >> 2;
		return (w[31:0] * 32'h9e3779b1) ^ w[63:32] ^ 32'h0badcafe;
	endfunction

	// eight tags over four sets give more tags than ways per set
	function automatic logic [63:0] make_addr(input logic [2:0] k, input logic [1:0] s,
		input logic [1:0] wd);
		tag_t t;
		t = tag_t'(k) * tag_t'(54'h10001) + tag_t'(54'h35);
		return {t, {4'b0, s}, wd, 2'b00};
	endfunction

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	// a zero hit mask means a miss that shows on the bus as a new wb_cyc
	task automatic check_hit(input string name, input way_mask_t exp, input logic got_miss);
		if (got_miss !== (exp == '0)) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got_miss, exp == '0);
			mismatch_cnt++;
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatch_cnt++;
		end
	endtask

	// a waiting request is held until accepted
	always @(posedge clk) begin
		if (!rst) begin
			if (!(req_valid && !req_ready)) begin
				if (n_acc < NUM_REQ) begin
					req_valid <= take_bits(2) != 0;
					req_addr  <= make_addr(take_bits(3), take_bits(2), take_bits(2));
				end else begin
					req_valid <= 1'b0;
				end
			end
			resp_ready <= take_bits(2) != 0;
			flush      <= take_bits(5) == 5'h1f;
			invalidate <= take_bits(6) == 6'h0;
			stall      <= take_bits(1);
		end
	end

	// model and monitor on pre-edge values
	always @(posedge clk) begin
		way_mask_t h;
		logic [63:0] a;
		logic exp_rdy;
		if (rst) begin
			sh_vld = '0;
			sh_victim = way_mask_t'(1);
			exp_inst.delete();
			exp_hit.delete();
			beat_cnt = 0;
			miss_pend = 1'b0;
			cyc_prev = 1'b0;
			cyc_rise = 1'b0;
			hit_acc = 1'b0;
		end else begin
			// ready only with no refill running and no answer that stays put
			// a waiting miss answer blocks even when it is taken
			exp_rdy = !flush && !miss_pend
				&& (exp_hit.size() == 0 || (resp_ready && exp_hit[0] != '0));
			check_ready("req_ready", req_ready, exp_rdy);
			if (wb_cyc && !cyc_prev) begin
				cyc_rise = 1'b1;
			end
			cyc_prev = wb_cyc;
			// hits answer in the cycle after acceptance
			if (hit_acc && !resp_valid) begin
				$display("Error at %0t: hit response not presented the cycle after acceptance",
					$time);
				other_cnt++;
			end
			hit_acc = 1'b0;
			if (resp_valid && resp_ready) begin
				if (exp_inst.size() == 0) begin
					$display("Error at %0t: response with no outstanding request", $time);
					other_cnt++;
				end else begin
					check_inst("resp_inst", resp_inst, exp_inst.pop_front());
					check_hit("miss", exp_hit.pop_front(), cyc_rise);
				end
			end
			// flushed answers never show but a running refill still installs
			if (flush) begin
				exp_inst.delete();
				exp_hit.delete();
			end
			if (req_valid && req_ready) begin
				a = req_addr;
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					h[w] = sh_vld[w][a[9:4]] && (sh_tag[w][a[9:4]] == a[63:10]);
				end
				exp_inst.push_back(mem_word(a));
				exp_hit.push_back(h);
				hit_acc = (h != '0);
				if (h == '0) begin
					miss_pend = 1'b1;
				end
				cyc_rise = 1'b0;
				pend_idx = a[9:4];
				pend_tag = a[63:10];
				n_acc <= n_acc + 1;
			end
			if (invalidate) begin
				sh_vld = '0;
			end
			// fourth ack installs into the victim and the pointer rotates
			if (wb_cyc && wb_ack) begin
				beat_cnt++;
				if (beat_cnt == 4) begin
					beat_cnt = 0;
					miss_pend = 1'b0;
					for (int w = 0; w < `ICACHE_WAYS; w++) begin
						if (sh_victim[w]) begin
							sh_vld[w][pend_idx] = 1'b1;
							sh_tag[w][pend_idx] = pend_tag;
						end
					end
					sh_victim = {sh_victim[`ICACHE_WAYS-2:0], sh_victim[`ICACHE_WAYS-1]};
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Timeout after %0d cycles with %0d requests accepted", cycle, n_acc);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		repeat (RESET_CYC) @(posedge clk);
		rst <= 1'b0;
		// drain once all requests are in
		do begin
			@(negedge clk);
		end while (n_acc < NUM_REQ || exp_inst.size() != 0 || wb_cyc || resp_valid);
		repeat (4) @(negedge clk);
		$display("mismatches %0d, other errors %0d, assertion failures %0d",
			mismatch_cnt, other_cnt, u_dut.u_assert.fail_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0 && u_dut.u_assert.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== testbench/icache_wb_mem.sv ====
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_wb_mem #(
	parameter int MAX_WAIT = 3
) (
	input  logic                      clk,
	input  logic                      rst,
	// wait request from the testbench lfsr, honoured up to MAX_WAIT cycles
	input  logic                      stall,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic [`ICACHE_ADDR_W-1:0] wb_adr,
	input  logic                      wb_we,
	output logic [`ICACHE_BUS_W-1:0]  wb_dat,
	output logic                      wb_ack
);

	int wait_cnt;

	// contents follow from the whole word address
	function automatic logic [31:0] mem_word(input logic [63:0] a);
		logic [63:0] w;
		w = a >> 2;
		return (w[31:0] * 32'h9e3779b1) ^ w[63:32] ^ 32'h0badcafe;
	endfunction

	// registered ack, one beat per request, reads only
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			wb_dat   <= '0;
			wait_cnt <= 0;
		end else if (wb_ack) begin
			wb_ack   <= 1'b0;
			wait_cnt <= 0;
		end else if (wb_cyc && wb_stb && !wb_we) begin
			if (stall && wait_cnt < MAX_WAIT) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				wb_ack <= 1'b1;
				wb_dat <= mem_word(wb_adr);
			end
		end
	end

endmodule
